// File: src.f
+incdir+hdl
hdl/lsu_pkg.sv
hdl/load_dispatch.sv
hdl/load_buffer_entry.sv
hdl/mem_stage.sv
hdl/load_store_unit.sv
verif/dmem_model.sv
verif/lsu_tb.sv

// File: verif/lsu_tb.sv
/* load/store unit testbench: clock, reset, watchdog,
   directed tests, result scoreboard and closing report */

`include "lsu_defines.svh"

module lsu_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import lsu_pkg::*;

	localparam int NUM_TESTS = 6;

	logic                  clock = 1'b0;
	logic                  reset;
	logic                  reject_enable;
	load_packet            load_in;
	store_packet           store_in;
	logic                  lb_full;
	dmem_request           dmem_req;
	logic [3:0]            dmem_response;
	logic [3:0]            dmem_tag;
	logic [`LSU_XLEN-1:0]  dmem_data;
	result_packet          result_out;

	// scoreboard, indexed by rob tag
	logic                  exp_live [32] = '{default: 1'b0};
	logic [`LSU_XLEN-1:0]  exp_addr [32];
	mem_size               exp_size [32];
	logic                  exp_uns [32];
	logic [`LSU_XLEN-1:0]  got_value [32]; // last result per tag
	logic [`ROB_TAG_W-1:0] next_rob;
	logic [`ROB_TAG_W-1:0] rtag;
	int                    outstanding = 0;
	int                    checks = 0;
	int                    value_errors = 0;
	int                    other_errors = 0;

	always #4 clock = ~clock; // 8 ns period

	load_store_unit dut (
		.clock         (clock),
		.reset         (reset),
		.load_in       (load_in),
		.store_in      (store_in),
		.lb_full       (lb_full),
		.dmem_req      (dmem_req),
		.dmem_response (dmem_response),
		.dmem_tag      (dmem_tag),
		.dmem_data     (dmem_data),
		.result_out    (result_out)
	);

	dmem_model dmem (
		.clock         (clock),
		.reset         (reset),
		.reject_enable (reject_enable),
		.dmem_req      (dmem_req),
		.dmem_response (dmem_response),
		.dmem_tag      (dmem_tag),
		.dmem_data     (dmem_data)
	);

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////

	// pick the lanes at the offset, then sign or zero extend
	function automatic logic [31:0] extend_load(input logic [31:0] word, input logic [1:0] offset,
			input mem_size sz, input logic uns);
		logic [31:0] lanes;
		lanes = word >> (8 * offset);
		case (sz)
			BYTE:    return uns ? {24'h0, lanes[7:0]} : {{24{lanes[7]}}, lanes[7:0]};
			HALF:    return uns ? {16'h0, lanes[15:0]} : {{16{lanes[15]}}, lanes[15:0]};
			default: return lanes;
		endcase
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			value_errors++;
			$display("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic print_counts();
		$display("checks %0d, value errors %0d, other errors %0d", checks, value_errors, other_errors);
	endtask

	task automatic send_load(input logic [31:0] addr, input mem_size sz, input logic uns);
		while (lb_full) @(negedge clock); // hold off while full
		assert (!exp_live[next_rob]) else begin
			other_errors++;
			$display("ROB tag %0d reused at %0t while still in flight", next_rob, $time);
		end
		exp_live[next_rob] = 1'b1;
		exp_addr[next_rob] = addr;
		exp_size[next_rob] = sz;
		exp_uns[next_rob]  = uns;
		outstanding++;
		load_in = '{valid: 1'b1, rob_tag: next_rob, address: addr, size: sz, is_unsigned: uns};
		next_rob++;
		@(negedge clock);
		load_in.valid = 1'b0; // one-cycle strobe
	endtask

	task automatic send_store(input logic [31:0] addr, input mem_size sz, input logic [31:0] data);
		store_in = '{valid: 1'b1, address: addr, size: sz, data: data};
		@(negedge clock);
		store_in.valid = 1'b0;
	endtask

	task automatic wait_drained();
		while (outstanding != 0) @(negedge clock); // watchdog guards this
	endtask

	// scoreboard, results sampled on the rising edge
	always @(posedge clock) begin
		if (!reset && result_out.valid) begin
			rtag = result_out.rob_tag;
			assert (exp_live[rtag]) else begin
				other_errors++;
				$display("result for ROB tag %0d at %0t, but no such load was in flight", rtag, $time);
			end
			if (exp_live[rtag]) begin
				check_value("result_out.value", result_out.value,
					extend_load(dmem.words[exp_addr[rtag][9:2]], exp_addr[rtag][1:0],
						exp_size[rtag], exp_uns[rtag]));
				got_value[rtag] = result_out.value;
				exp_live[rtag]  = 1'b0;
				outstanding--;
			end
		end
	end

	//////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////
	task automatic test_reset_state();
		check_value("dmem_req.command", 32'(dmem_req.command), 32'(BUS_NONE));
		check_value("result_out.valid", 32'(result_out.valid), 32'd0);
		check_value("lb_full", 32'(lb_full), 32'd0);
	endtask

	// word 5 holds 0x87878785, every byte has its top bit set
	task automatic test_single_loads();
		mem_size               sizes [3];
		logic [31:0]           addrs [3];
		logic [`ROB_TAG_W-1:0] tag;
		sizes = '{BYTE, HALF, WORD};
		addrs = '{32'h15, 32'h16, 32'h14};
		for (int s = 0; s < 3; s++) begin
			for (int u = 0; u < 2; u++) begin
				tag = next_rob;
				send_load(addrs[s], sizes[s], u[0]);
				wait_drained();
				if (sizes[s] != WORD) begin
					check_value("result_out.value[31]", 32'(got_value[tag][31]), 32'(!u[0]));
				end
			end
		end
	endtask

	task automatic test_store_then_load();
		logic [31:0]           old_word;
		logic [`ROB_TAG_W-1:0] tag;
		old_word = dmem.words[12];
		send_store(32'h31, BYTE, 32'hFFFF_FFC3); // upper lanes must not land
		tag = next_rob;
		send_load(32'h31, BYTE, 1'b0);
		wait_drained();
		check_value("byte after store", got_value[tag], 32'hFFFF_FFC3);
		tag = next_rob;
		send_load(32'h30, WORD, 1'b0);
		wait_drained();
		check_value("word around stored byte", got_value[tag], (old_word & 32'hFFFF_00FF) | 32'hC300);
		send_store(32'h32, HALF, 32'h1234_8F0E);
		tag = next_rob;
		send_load(32'h32, HALF, 1'b1);
		wait_drained();
		check_value("unsigned half after store", got_value[tag], 32'h0000_8F0E);
	endtask

	task automatic test_fill_buffer();
		for (int i = 0; i < 4; i++) begin
			send_load(32'h40 + 4 * i, WORD, 1'b0); // back to back
		end
		check_value("lb_full", 32'(lb_full), 32'd1);
		wait_drained(); // each tag retired once by the scoreboard
	endtask

	task automatic test_random_with_reject();
		int          start_rejects;
		logic [31:0] addr;
		mem_size     sz;
		reject_enable = 1'b1;
		start_rejects = dmem.reject_count;
		repeat (20) begin
			sz   = mem_size'($urandom_range(2));
			addr = $urandom & 32'h3FF;
			if (sz == HALF) addr[0] = 1'b0;
			if (sz == WORD) addr[1:0] = 2'b00;
			send_load(addr, sz, 1'($urandom_range(1)));
		end
		wait_drained();
		reject_enable = 1'b0;
		assert (dmem.reject_count > start_rejects) else begin
			other_errors++;
			$display("no load was rejected, the retry path was never used");
		end
	endtask

	task automatic test_store_beside_loads();
		send_load(32'h50, BYTE, 1'b0);
		// the first load is pending and the stage is ready, the store must win
		store_in = '{valid: 1'b1, address: 32'hA0, size: WORD, data: 32'h5A5A_1234};
		#1; // combinational path to the bus
		check_value("dmem_req.command", 32'(dmem_req.command), 32'(BUS_STORE));
		check_value("dmem_req.address", dmem_req.address, 32'hA0);
		@(negedge clock);
		store_in.valid = 1'b0;
		send_load(32'h56, HALF, 1'b0);
		send_load(32'h58, WORD, 1'b0);
		wait_drained();
		check_value("stored word", dmem.words[40], 32'h5A5A_1234);
	endtask

	//////////////////////////////////////////////////
	// main sequence and watchdog
	//////////////////////////////////////////////////
	initial begin
		void'($urandom(32'h16170e18));
		reset         = 1'b1;
		reject_enable = 1'b0;
		load_in       = '0;
		store_in      = '0;
		next_rob      = '0;
		repeat (4) @(negedge clock);
		reset = 1'b0;
		test_reset_state();
		test_single_loads();
		test_store_then_load();
		test_fill_buffer();
		test_random_with_reject();
		test_store_beside_loads();
		repeat (2) @(negedge clock);
		print_counts();
		if (value_errors + other_errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

	initial begin
		#(NUM_TESTS * 2000);
		other_errors++;
		$display("watchdog expired at %0t, tests did not finish", $time);
		print_counts();
		$display("TEST FAIL");
		$finish;
	end

endmodule

// File: verif/dmem_model.sv
/* data-memory model: word array, tagged load data after
   a fixed latency, random request rejection, masked stores */

`include "lsu_defines.svh"

module dmem_model (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 reject_enable,
	input  lsu_pkg::dmem_request dmem_req,
	output logic [3:0]           dmem_response, // 0 = rejected
	output logic [3:0]           dmem_tag,      // 0 = nothing returning
	output logic [`LSU_XLEN-1:0] dmem_data
);
	timeunit 1ns;
	timeprecision 100ps;
	import lsu_pkg::*;

	logic [`LSU_XLEN-1:0] words [256];
	logic [3:0]           next_tag;          // cycles 1..15
	logic                 roll = 1'b0;       // reject draw for this cycle
	logic [3:0]           line_tag [4];      // latency line
	logic [`LSU_XLEN-1:0] line_data [4];
	int                   reject_count = 0;
	logic [7:0]           idx;
	logic [4:0]           shift;

	initial begin
		for (int i = 0; i < 256; i++) begin
			words[i] = i * 32'h8181_8181; // depends on every address bit
		end
	end

	assign idx   = dmem_req.address[9:2];
	assign shift = {dmem_req.address[1:0], 3'b000}; // byte lane in bits

	always @(negedge clock) begin
		roll <= ($urandom_range(3) == 0); // one in four
	end

	always_comb begin
		case (dmem_req.command)
			BUS_LOAD:  dmem_response = (reject_enable && roll) ? 4'h0 : next_tag;
			BUS_STORE: dmem_response = next_tag; // the unit never retries a store
			default:   dmem_response = 4'h0;
		endcase
	end

	assign dmem_tag  = line_tag[3];
	assign dmem_data = line_data[3];

	//////////////////////////////////////////////////
	// latency line and stores
	//////////////////////////////////////////////////
	always @(posedge clock) begin
		if (reset) begin
			next_tag  <= 4'h1;
			line_tag  <= '{default: 4'h0};
			line_data <= '{default: '0};
		end else begin
			for (int s = 3; s > 0; s--) begin
				line_tag[s]  <= line_tag[s-1];
				line_data[s] <= line_data[s-1];
			end
			line_tag[0]  <= 4'h0;
			line_data[0] <= '0;
			if (dmem_req.command == BUS_LOAD && dmem_response != 4'h0) begin
				line_tag[0]  <= dmem_response;
				line_data[0] <= words[idx] >> shift; // accessed bytes in low lanes
				next_tag     <= (next_tag == 4'hF) ? 4'h1 : next_tag + 4'h1;
			end
			if (dmem_req.command == BUS_LOAD && dmem_response == 4'h0) begin
				reject_count <= reject_count + 1;
			end
			if (dmem_req.command == BUS_STORE) begin
				case (dmem_req.size)
					BYTE:    words[idx][shift +: 8]  <= dmem_req.data[7:0];
					HALF:    words[idx][shift +: 16] <= dmem_req.data[15:0];
					default: words[idx]              <= dmem_req.data;
				endcase
			end
		end
	end

endmodule

// File: hdl/load_store_unit.sv
/* load/store unit top: dispatch, load-buffer entry array
   and memory stage */

`include "lsu_defines.svh"

module load_store_unit (
	input  logic                  clock,
	input  logic                  reset,
	input  lsu_pkg::load_packet   load_in,       // from dispatch
	input  lsu_pkg::store_packet  store_in,      // from commit
	output logic                  lb_full,
	output lsu_pkg::dmem_request  dmem_req,
	input  logic [3:0]            dmem_response, // 0 = rejected
	input  logic [3:0]            dmem_tag,
	input  logic [`LSU_XLEN-1:0]  dmem_data,
	output lsu_pkg::result_packet result_out     // write-back strobe
);
	import lsu_pkg::*;

	logic [`LB_DEPTH-1:0]       alloc;
	logic [`LB_DEPTH-1:0]       grant;
	logic [`LB_DEPTH-1:0]       done;
	logic [`LB_DEPTH-1:0]       retry;
	logic [`LB_DEPTH-1:0]       request;
	logic [`LB_DEPTH-1:0]       empty;
	load_packet [`LB_DEPTH-1:0] entries; // held packets

	load_dispatch u_dispatch (
		.clock       (clock),
		.reset       (reset),
		.load_in     (load_in),
		.entry_empty (empty),
		.alloc       (alloc),
		.lb_full     (lb_full)
	);

	//////////////////////////////////////////////////
	// load buffer
	//////////////////////////////////////////////////
	for (genvar i = 0; i < `LB_DEPTH; i++) begin : g_entry
		load_buffer_entry u_entry (
			.clock   (clock),
			.reset   (reset),
			.alloc   (alloc[i]),
			.grant   (grant[i]),
			.done    (done[i]),
			.retry   (retry[i]),
			.load_in (load_in),  // captured only by the allocated slot
			.entry   (entries[i]),
			.request (request[i]),
			.empty   (empty[i])
		);
	end

	mem_stage #(.MTAG_W(4)) u_mem_stage (
		.clock         (clock),
		.reset         (reset),
		.store_in      (store_in),
		.request       (request),
		.entries       (entries),
		.dmem_response (dmem_response),
		.dmem_tag      (dmem_tag),
		.dmem_data     (dmem_data),
		.dmem_req      (dmem_req),
		.grant         (grant),
		.done          (done),
		.retry         (retry),
		.result_out    (result_out)
	);

endmodule

// File: hdl/mem_stage.sv
/* memory stage: store/load bus mux, outstanding-tag FSM,
   load data extension and result strobe */

`include "lsu_defines.svh"

module mem_stage #(
	parameter int MTAG_W = 4 // memory tag width, tag 0 means rejected
) (
	input  logic                                 clock,
	input  logic                                 reset,
	input  lsu_pkg::store_packet                 store_in,      // committed store strobe
	input  logic [`LB_DEPTH-1:0]                 request,       // pending entries
	input  lsu_pkg::load_packet [`LB_DEPTH-1:0]  entries,
	input  logic [MTAG_W-1:0]                    dmem_response, // same cycle as request
	input  logic [MTAG_W-1:0]                    dmem_tag,      // data return tag
	input  logic [`LSU_XLEN-1:0]                 dmem_data,
	output lsu_pkg::dmem_request                 dmem_req,
	output logic [`LB_DEPTH-1:0]                 grant,
	output logic [`LB_DEPTH-1:0]                 done,
	output logic [`LB_DEPTH-1:0]                 retry,
	output lsu_pkg::result_packet                result_out
);
	import lsu_pkg::*;

	localparam int IDX_W = $clog2(`LB_DEPTH);

	mem_state             state;
	logic [MTAG_W-1:0]    recorded_tag; // response of the outstanding load
	logic [IDX_W-1:0]     issued_idx;   // entry that owns it
	logic [`LB_DEPTH-1:0] reject_q;     // rejected grant, answered next cycle
	logic [IDX_W-1:0]     sel_idx;
	logic                 sel_found;
	logic                 issue;
	logic                 accepted;
	logic                 tag_hit;
	load_packet           hit_load;
	logic [`LSU_XLEN-1:0] load_value;
	logic [`LB_DEPTH-1:0] issued_set;   // entries holding a grant

	//////////////////////////////////////////////////
	// load select and bus mux
	//////////////////////////////////////////////////

	// lowest pending index wins, scan from the top down
	always_comb begin
		sel_idx   = '0;
		sel_found = 1'b0;
		for (int i = `LB_DEPTH - 1; i >= 0; i--) begin
			if (request[i]) begin
				sel_idx   = IDX_W'(i);
				sel_found = 1'b1;
			end
		end
	end

	// stores always win; one load in flight at a time
	assign issue    = sel_found && !store_in.valid && (state == READY) && (reject_q == '0);
	assign accepted = issue && (dmem_response != '0);
	assign tag_hit  = (state == MEM_WAIT) && (dmem_tag == recorded_tag);

	always_comb begin
		dmem_req = '{command: BUS_NONE, size: BYTE, address: '0, data: '0};
		if (store_in.valid) begin
			dmem_req.command = BUS_STORE;
			dmem_req.size    = store_in.size;
			dmem_req.address = store_in.address;
			dmem_req.data    = store_in.data;
		end else if (issue) begin
			dmem_req.command = BUS_LOAD;
			dmem_req.size    = entries[sel_idx].size;
			dmem_req.address = entries[sel_idx].address;
		end
	end

	assign grant = issue ? (`LB_DEPTH'(1) << sel_idx) : '0;
	assign retry = reject_q;                                       // back to pending
	assign done  = reject_q | (tag_hit ? (`LB_DEPTH'(1) << issued_idx) : '0);

	//////////////////////////////////////////////////
	// outstanding load FSM
	//////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			state        <= READY;
			recorded_tag <= '0;
			issued_idx   <= '0;
			reject_q     <= '0;
		end else begin
			reject_q <= (issue && !accepted) ? grant : '0;
			case (state)
				READY: begin
					if (accepted) begin
						state        <= MEM_WAIT;
						recorded_tag <= dmem_response;
						issued_idx   <= sel_idx;
					end
				end
				MEM_WAIT: begin
					if (tag_hit) begin
						state <= READY; // data is back this cycle
					end
				end
				default: state <= READY;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// data extension and result
	//////////////////////////////////////////////////
	assign hit_load = entries[issued_idx];

	// dmem_data carries the accessed bytes in its low lanes
	always_comb begin
		case (hit_load.size)
			BYTE: load_value = hit_load.is_unsigned
				? {{(`LSU_XLEN - 8){1'b0}}, dmem_data[7:0]}
				: {{(`LSU_XLEN - 8){dmem_data[7]}}, dmem_data[7:0]};
			HALF: load_value = hit_load.is_unsigned
				? {{(`LSU_XLEN - 16){1'b0}}, dmem_data[15:0]}
				: {{(`LSU_XLEN - 16){dmem_data[15]}}, dmem_data[15:0]};
			default: load_value = dmem_data; // full word
		endcase
	end

	assign result_out.valid   = tag_hit;
	assign result_out.rob_tag = hit_load.rob_tag;
	assign result_out.value   = load_value;

	//////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////

	// a live entry that no longer requests has been granted
	always_comb begin
		for (int i = 0; i < `LB_DEPTH; i++) begin
			issued_set[i] = entries[i].valid && !request[i];
		end
	end

	a_one_grant: assert property (
		@(posedge clock) disable iff (reset)
		$onehot0(issued_set)
	);

	// while waiting, only the owner of the tag is issued
	a_no_load_in_wait: assert property (
		@(posedge clock) disable iff (reset)
		(state == MEM_WAIT) |-> (issued_set == (`LB_DEPTH'(1) << issued_idx))
	);

	// no double-word access at xlen 32
	a_size_max_word: assert property (
		@(posedge clock) disable iff (reset)
		(dmem_req.command != BUS_NONE) |-> (dmem_req.size inside {BYTE, HALF, WORD})
	);

	// returning data must belong to a live buffer slot
	a_result_owner_live: assert property (
		@(posedge clock) disable iff (reset)
		tag_hit |-> hit_load.valid
	);

endmodule

// File: hdl/load_buffer_entry.sv
/* one load-buffer slot: holds a load packet and steps
   through empty, pending and issued */

`include "lsu_defines.svh"

module load_buffer_entry (
	input  logic                clock,
	input  logic                reset,
	input  logic                alloc,   // from dispatch
	input  logic                grant,   // from mem stage, load on the bus
	input  logic                done,    // data back or request rejected
	input  logic                retry,   // with done, request rejected
	input  lsu_pkg::load_packet load_in,
	output lsu_pkg::load_packet entry,   // held packet to mem stage
	output logic                request, // waiting for the bus
	output logic                empty
);
	import lsu_pkg::*;

	entry_state state;
	entry_state next_state;
	load_packet held; // payload, no reset

	//////////////////////////////////////////////////
	// state machine
	//////////////////////////////////////////////////
	always_comb begin
		next_state = state;
		case (state)
			EMPTY: begin
				if (alloc) begin
					next_state = PENDING;
				end
			end
			PENDING: begin
				if (grant) begin
					next_state = ISSUED;
				end
			end
			ISSUED: begin
				if (done) begin
					next_state = retry ? PENDING : EMPTY; // rejected goes back
				end
			end
			default: next_state = EMPTY;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= EMPTY;
		end else begin
			state <= next_state;
		end
	end

	// capture payload on allocation
	always_ff @(posedge clock) begin
		if (alloc) begin
			held <= load_in;
		end
	end

	// valid follows the slot state, not the stale payload
	always_comb begin
		entry       = held;
		entry.valid = (state != EMPTY);
	end

	assign request = (state == PENDING);
	assign empty   = (state == EMPTY);

	//////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////
	a_grant_when_pending: assert property (
		@(posedge clock) disable iff (reset)
		grant |-> (state == PENDING)
	);

	a_done_when_issued: assert property (
		@(posedge clock) disable iff (reset)
		done |-> (state == ISSUED)
	);

endmodule

// File: hdl/load_dispatch.sv
/* load dispatch: picks the lowest free load-buffer entry for
   each incoming load and flags a full buffer */

`include "lsu_defines.svh"

module load_dispatch (
	input  logic                 clock,
	input  logic                 reset,
	input  lsu_pkg::load_packet  load_in,     // one-cycle strobe from dispatch
	input  logic [`LB_DEPTH-1:0] entry_empty, // one bit per slot
	output logic [`LB_DEPTH-1:0] alloc,       // one-hot, lowest free slot
	output logic                 lb_full
);

	logic [`LB_DEPTH-1:0] lock;   // slots handed out last cycle
	logic [`LB_DEPTH-1:0] free;
	logic [`LB_DEPTH-1:0] lowest; // lowest set bit of free

	// a slot counts as free only if the entry reports empty
	// and it was not just allocated
	assign free = entry_empty & ~lock;

	// priority encoder, isolate the lowest set bit
	assign lowest = free & (~free + `LB_DEPTH'(1));

	assign alloc   = load_in.valid ? lowest : '0;
	assign lb_full = ~|free; // sender must hold off

	//////////////////////////////////////////////////
	// occupancy lock
	//////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			lock <= '0;
		end else begin
			lock <= alloc; // held for one cycle only
		end
	end

	//////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////

	// dispatch side must respect lb_full
	a_no_load_when_full: assert property (
		@(posedge clock) disable iff (reset)
		load_in.valid |-> !lb_full
	);

endmodule

// File: hdl/lsu_pkg.sv
/* load/store unit types: bus command, access size, entry and
   memory-stage state enums, load/store/result/bus packets */

`include "lsu_defines.svh"

package lsu_pkg;

	//////////////////////////////////////////////////
	// enums
	//////////////////////////////////////////////////
	typedef enum logic [1:0] {
		BUS_NONE  = 2'h0, // idle bus
		BUS_LOAD  = 2'h1,
		BUS_STORE = 2'h2
	} bus_command;

	typedef enum logic [1:0] {
		BYTE = 2'h0,
		HALF = 2'h1,
		WORD = 2'h2 // widest access at xlen 32
	} mem_size;

	typedef enum logic [1:0] {EMPTY, PENDING, ISSUED} entry_state; // buffer slot

	typedef enum logic {READY, MEM_WAIT} mem_state; // memory stage

	//////////////////////////////////////////////////
	// packets
	//////////////////////////////////////////////////
	typedef struct packed {
		logic                  valid;
		logic [`ROB_TAG_W-1:0] rob_tag;     // write-back slot
		logic [`LSU_XLEN-1:0]  address;
		mem_size               size;
		logic                  is_unsigned; // lbu / lhu
	} load_packet;

	typedef struct packed {
		logic                 valid;   // committed store strobe
		logic [`LSU_XLEN-1:0] address;
		mem_size              size;
		logic [`LSU_XLEN-1:0] data;    // low bytes used per size
	} store_packet;

	typedef struct packed {
		logic                  valid;
		logic [`ROB_TAG_W-1:0] rob_tag;
		logic [`LSU_XLEN-1:0]  value;  // already extended
	} result_packet;

	typedef struct packed {
		bus_command           command;
		mem_size              size;
		logic [`LSU_XLEN-1:0] address;
		logic [`LSU_XLEN-1:0] data;    // store data only
	} dmem_request;

endpackage

// File: hdl/lsu_defines.svh
/* width and depth macros for the load/store unit:
   data width, load-buffer depth, ROB tag width */

`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

//////////////////////////////////////////////////
// datapath
//////////////////////////////////////////////////
`define LSU_XLEN 32 // data and address width, one word

//////////////////////////////////////////////////
// load buffer
//////////////////////////////////////////////////
`define LB_DEPTH 4 // load-buffer entries, 2 or more

// tag of the reorder buffer slot a load writes back to
`define ROB_TAG_W 5

`endif
